// File: verilog/soc_map_pkg.sv
/*
  Address map and access response types for the SoC access gate.
  The decode, execute and result stages and the top import this package.
  The MCU SRAM size is a module parameter and is not defined here.
*/
package soc_map_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int ADDR_W = 32;
    localparam int USER_W = 32;

    ////////////////////
    // Region bases
    ////////////////////
    localparam logic [ADDR_W-1:0] MCU_SRAM_BASE = 32'h2100_0000;
    localparam logic [ADDR_W-1:0] SRAM_CFG_BASE = 32'h2120_0000;
    localparam logic [ADDR_W-1:0] MCI_CFG_BASE  = 32'h2130_0000;

    // Both config windows are one 4 KB page
    localparam int CFG_WIN_BYTES = 4096;

    // Decoded target of a request
    typedef enum logic [1:0] {
        REGION_NONE     = 2'd0,
        REGION_MCU_SRAM = 2'd1,
        REGION_SRAM_CFG = 2'd2,
        REGION_MCI_CFG  = 2'd3
    } region_e;

    // Response code, in order of rule priority
    typedef enum logic [1:0] {
        ERR_OK        = 2'd0,
        ERR_DECODE    = 2'd1,
        ERR_USER      = 2'd2,
        ERR_NOT_READY = 2'd3
    } access_err_e;

endpackage

// File: verilog/soc_rst_pkg.sv
/*
  Types for the power-good and core reset sequencer.
  Only the sequencer imports this package.
*/
package soc_rst_pkg;

    // Delay counter width, so up to 65535 cycles per step
    localparam int DLY_W = 16;

    // Idle states hold a level pair, wait states run the delay
    typedef enum logic [2:0] {
        ST_OFF      = 3'd0,  // Power-good low, core in reset
        ST_PWR_WAIT = 3'd1,  // Delay before a power-good change
        ST_PWR_ON   = 3'd2,  // Power-good high, core in reset
        ST_RST_WAIT = 3'd3,  // Delay before a core reset change
        ST_RUN      = 3'd4   // Both levels high
    } rst_state_e;

endpackage

// File: verilog/soc_addr_decode.sv
/*
  Decode stage of the access pipeline.
  Maps each request address to a region of the SoC map and registers
  the region with the user value and write flag for the execute stage.
  MCU_SRAM_SIZE_KB comes from the top, up to 2048 KB.
*/
`timescale 1ns/1ns

module soc_addr_decode #(
    parameter int MCU_SRAM_SIZE_KB = 512
) (
    input  logic                           core_clk,
    input  logic                           rst_n_i,
    input  logic                           req_valid_i,
    input  logic [soc_map_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [soc_map_pkg::USER_W-1:0] req_user_i,
    input  logic                           req_write_i,
    output logic                           dec_valid_o,
    output soc_map_pkg::region_e           dec_region_o,
    output logic [soc_map_pkg::USER_W-1:0] dec_user_o,
    output logic                           dec_write_o
);
    import soc_map_pkg::*;

    // Region limits, upper bound exclusive
    localparam logic [ADDR_W-1:0] SRAM_BYTES   = ADDR_W'(MCU_SRAM_SIZE_KB * 1024);
    localparam logic [ADDR_W-1:0] SRAM_END     = MCU_SRAM_BASE + SRAM_BYTES;
    localparam logic [ADDR_W-1:0] SRAM_CFG_END = SRAM_CFG_BASE + ADDR_W'(CFG_WIN_BYTES);
    localparam logic [ADDR_W-1:0] MCI_CFG_END  = MCI_CFG_BASE + ADDR_W'(CFG_WIN_BYTES);

    logic    hit_sram;
    logic    hit_sram_cfg;
    logic    hit_mci_cfg;
    region_e region_d;

    ////////////////////
    // Address compare
    ////////////////////
    always_comb begin
        hit_sram     = (req_addr_i >= MCU_SRAM_BASE) && (req_addr_i < SRAM_END);
        hit_sram_cfg = (req_addr_i >= SRAM_CFG_BASE) && (req_addr_i < SRAM_CFG_END);
        hit_mci_cfg  = (req_addr_i >= MCI_CFG_BASE) && (req_addr_i < MCI_CFG_END);

        // Regions never overlap, order only matters for readability
        if (hit_sram) begin
            region_d = REGION_MCU_SRAM;
        end else if (hit_sram_cfg) begin
            region_d = REGION_SRAM_CFG;
        end else if (hit_mci_cfg) begin
            region_d = REGION_MCI_CFG;
        end else begin
            region_d = REGION_NONE;
        end
    end

    ////////////////////
    // Stage register
    ////////////////////
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= req_valid_i;
        end
    end

    // Payload only moves with a request
    always_ff @(posedge core_clk) begin
        if (req_valid_i) begin
            dec_region_o <= region_d;
            dec_user_o   <= req_user_i;
            dec_write_o  <= req_write_i;
        end
    end

endmodule

// File: verilog/soc_user_check.sv
/*
  Execute stage of the access pipeline.
  Checks a decoded request against the core reset level and the five
  strap users, then registers grant, error code and region.
  Priority is reset state, then decode, then user and write flag.
*/
`timescale 1ns/1ns

module soc_user_check (
    input  logic                           core_clk,
    input  logic                           rst_n_i,
    input  logic                           dec_valid_i,
    input  soc_map_pkg::region_e           dec_region_i,
    input  logic [soc_map_pkg::USER_W-1:0] dec_user_i,
    input  logic                           dec_write_i,
    input  logic                           core_rst_b_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_lsu_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_ifu_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_dma_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_sram_cfg_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_mci_cfg_user_i,
    output logic                           exe_valid_o,
    output logic                           exe_grant_o,
    output soc_map_pkg::access_err_e       exe_err_o,
    output soc_map_pkg::region_e           exe_region_o
);
    import soc_map_pkg::*;

    logic        user_ok;
    access_err_e err_d;

    ////////////////////
    // User rules
    ////////////////////
    always_comb begin
        case (dec_region_i)
            // LSU and DMA read or write, IFU fetches only
            REGION_MCU_SRAM: begin
                user_ok = (dec_user_i == strap_lsu_user_i)
                       || (dec_user_i == strap_dma_user_i)
                       || ((dec_user_i == strap_ifu_user_i) && !dec_write_i);
            end
            REGION_SRAM_CFG: begin
                user_ok = (dec_user_i == strap_sram_cfg_user_i);
            end
            REGION_MCI_CFG: begin
                user_ok = (dec_user_i == strap_mci_cfg_user_i);
            end
            default: begin
                user_ok = 1'b0;
            end
        endcase
    end

    // Verdict in priority order
    always_comb begin
        if (!core_rst_b_i) begin
            err_d = ERR_NOT_READY;
        end else if (dec_region_i == REGION_NONE) begin
            err_d = ERR_DECODE;
        end else if (!user_ok) begin
            err_d = ERR_USER;
        end else begin
            err_d = ERR_OK;
        end
    end

    ////////////////////
    // Stage register
    ////////////////////
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            exe_valid_o <= 1'b0;
            exe_grant_o <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
            exe_grant_o <= dec_valid_i && (err_d == ERR_OK);
        end
    end

    always_ff @(posedge core_clk) begin
        exe_err_o    <= err_d;
        exe_region_o <= dec_region_i;
    end

endmodule

// File: verilog/soc_access_result.sv
/*
  Result stage of the access pipeline.
  Registers the response seen by the bus side and keeps a saturating
  count of denied requests.
*/
`timescale 1ns/1ns

module soc_access_result (
    input  logic                     core_clk,
    input  logic                     rst_n_i,
    input  logic                     exe_valid_i,
    input  logic                     exe_grant_i,
    input  soc_map_pkg::access_err_e exe_err_i,
    input  soc_map_pkg::region_e     exe_region_i,
    output logic                     resp_valid_o,
    output logic                     resp_grant_o,
    output soc_map_pkg::access_err_e resp_err_o,
    output soc_map_pkg::region_e     resp_region_o,
    output logic [15:0]              deny_count_o
);

    logic deny;

    // Valid result without a grant
    assign deny = exe_valid_i && !exe_grant_i;

    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            resp_valid_o <= 1'b0;
            resp_grant_o <= 1'b0;
            deny_count_o <= '0;
        end else begin
            resp_valid_o <= exe_valid_i;
            resp_grant_o <= exe_valid_i && exe_grant_i;
            // Holds at all ones
            if (deny && (deny_count_o != '1)) begin
                deny_count_o <= deny_count_o + 1'b1;
            end
        end
    end

    // Code and region are only meaningful with resp_valid_o
    always_ff @(posedge core_clk) begin
        resp_err_o    <= exe_err_i;
        resp_region_o <= exe_region_i;
    end

endmodule

// File: verilog/soc_rst_seq.sv
/*
  Power-good and core reset sequencer.
  Raises power-good and then the core reset after fixed delays at boot.
  Afterwards serves one assert or release request at a time and pulses
  the matching done output when the level changes. The core reset
  never leaves while power-good is low.
*/
`timescale 1ns/1ns

module soc_rst_seq #(
    parameter int RST_DELAY_CYCLES = 8
) (
    input  logic core_clk,
    input  logic rst_n_i,
    input  logic hard_rst_assert_req_i,
    input  logic hard_rst_release_req_i,
    input  logic core_rst_assert_req_i,
    input  logic core_rst_release_req_i,
    output logic pwrgood_o,
    output logic core_rst_b_o,
    output logic hard_rst_assert_done_o,
    output logic hard_rst_release_done_o,
    output logic core_rst_assert_done_o,
    output logic core_rst_release_done_o
);
    import soc_rst_pkg::*;

    // Last count of a wait, the count starts at the request pulse
    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(RST_DELAY_CYCLES - 1);

    rst_state_e       state_q;
    logic [DLY_W-1:0] dly_cnt_q;
    logic             op_assert_q;
    logic             boot_q;
    logic             hard_req;
    logic             any_req;
    logic             dly_done;

    // Idle state that matches a pair of levels
    function automatic rst_state_e idle_state(input logic pg, input logic rb);
        if (!pg) begin
            return ST_OFF;
        end
        return rb ? ST_RUN : ST_PWR_ON;
    endfunction

    assign hard_req = hard_rst_assert_req_i | hard_rst_release_req_i;
    assign any_req  = hard_req | core_rst_assert_req_i | core_rst_release_req_i;
    assign dly_done = (dly_cnt_q >= DLY_LAST);

    ////////////////////
    // Sequencer FSM
    ////////////////////
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            // Boot runs as a hard release chained into a core release
            state_q      <= ST_PWR_WAIT;
            dly_cnt_q    <= '0;
            op_assert_q  <= 1'b0;
            boot_q       <= 1'b1;
            pwrgood_o    <= 1'b0;
            core_rst_b_o <= 1'b0;
            hard_rst_assert_done_o  <= 1'b0;
            hard_rst_release_done_o <= 1'b0;
            core_rst_assert_done_o  <= 1'b0;
            core_rst_release_done_o <= 1'b0;
        end else begin
            // Done outputs are one cycle pulses
            hard_rst_assert_done_o  <= 1'b0;
            hard_rst_release_done_o <= 1'b0;
            core_rst_assert_done_o  <= 1'b0;
            core_rst_release_done_o <= 1'b0;

            case (state_q)
                ST_OFF, ST_PWR_ON, ST_RUN: begin
                    // Hard requests first, assert before release
                    if (any_req) begin
                        dly_cnt_q   <= DLY_W'(1);
                        op_assert_q <= hard_rst_assert_req_i
                                    | (!hard_rst_release_req_i & core_rst_assert_req_i);
                        state_q     <= hard_req ? ST_PWR_WAIT : ST_RST_WAIT;
                    end
                end

                ST_PWR_WAIT: begin
                    if (!dly_done) begin
                        dly_cnt_q <= dly_cnt_q + 1'b1;
                    end else if (op_assert_q) begin
                        // Hard reset drops both levels together
                        pwrgood_o              <= 1'b0;
                        core_rst_b_o           <= 1'b0;
                        hard_rst_assert_done_o <= 1'b1;
                        state_q                <= ST_OFF;
                    end else begin
                        pwrgood_o <= 1'b1;
                        if (boot_q) begin
                            dly_cnt_q <= '0;
                            state_q   <= ST_RST_WAIT;
                        end else begin
                            hard_rst_release_done_o <= 1'b1;
                            state_q                 <= idle_state(1'b1, core_rst_b_o);
                        end
                    end
                end

                ST_RST_WAIT: begin
                    if (!dly_done) begin
                        dly_cnt_q <= dly_cnt_q + 1'b1;
                    end else if (op_assert_q) begin
                        core_rst_b_o           <= 1'b0;
                        core_rst_assert_done_o <= 1'b1;
                        state_q                <= idle_state(pwrgood_o, 1'b0);
                    end else begin
                        // Release only takes hold with power good
                        core_rst_b_o            <= pwrgood_o;
                        core_rst_release_done_o <= !boot_q;
                        boot_q                  <= 1'b0;
                        state_q                 <= idle_state(pwrgood_o, pwrgood_o);
                    end
                end

                default: begin
                    state_q <= ST_OFF;
                end
            endcase
        end
    end

endmodule

// File: verilog/soc_access_top.sv
/*
  Top of the SoC access gate.
  Holds the five strap registers, sampled while rst_n_i is low, and ties
  the decode, execute and result stages to the reset sequencer.
  A request strobed in gets one response three cycles later.
*/
`timescale 1ns/1ns

module soc_access_top #(
    parameter int MCU_SRAM_SIZE_KB = 512,
    parameter int RST_DELAY_CYCLES = 8
) (
    input  logic                           core_clk,
    input  logic                           rst_n_i,
    input  logic                           hard_rst_assert_req_i,
    input  logic                           hard_rst_release_req_i,
    input  logic                           core_rst_assert_req_i,
    input  logic                           core_rst_release_req_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_lsu_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_ifu_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_dma_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_sram_cfg_user_i,
    input  logic [soc_map_pkg::USER_W-1:0] strap_mci_cfg_user_i,
    input  logic                           req_valid_i,
    input  logic [soc_map_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [soc_map_pkg::USER_W-1:0] req_user_i,
    input  logic                           req_write_i,
    output logic                           pwrgood_o,
    output logic                           core_rst_b_o,
    output logic                           hard_rst_assert_done_o,
    output logic                           hard_rst_release_done_o,
    output logic                           core_rst_assert_done_o,
    output logic                           core_rst_release_done_o,
    output logic                           resp_valid_o,
    output logic                           resp_grant_o,
    output soc_map_pkg::access_err_e       resp_err_o,
    output soc_map_pkg::region_e           resp_region_o,
    output logic [15:0]                    deny_count_o
);
    import soc_map_pkg::*;

    // Strap copies
    logic [USER_W-1:0] lsu_user_q;
    logic [USER_W-1:0] ifu_user_q;
    logic [USER_W-1:0] dma_user_q;
    logic [USER_W-1:0] sram_cfg_user_q;
    logic [USER_W-1:0] mci_cfg_user_q;

    // Decode to execute
    logic              dec_valid;
    region_e           dec_region;
    logic [USER_W-1:0] dec_user;
    logic              dec_write;

    // Execute to result
    logic              exe_valid;
    logic              exe_grant;
    access_err_e       exe_err;
    region_e           exe_region;

    ////////////////////
    // Strap capture
    ////////////////////
    // Follows the pins during reset, frozen after release
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            lsu_user_q      <= strap_lsu_user_i;
            ifu_user_q      <= strap_ifu_user_i;
            dma_user_q      <= strap_dma_user_i;
            sram_cfg_user_q <= strap_sram_cfg_user_i;
            mci_cfg_user_q  <= strap_mci_cfg_user_i;
        end
    end

    ////////////////////
    // Access pipeline
    ////////////////////
    soc_addr_decode #(
        .MCU_SRAM_SIZE_KB(MCU_SRAM_SIZE_KB)
    ) u_decode (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_user_i   (req_user_i),
        .req_write_i  (req_write_i),
        .dec_valid_o  (dec_valid),
        .dec_region_o (dec_region),
        .dec_user_o   (dec_user),
        .dec_write_o  (dec_write)
    );

    // Core reset level gates every grant
    soc_user_check u_check (
        .core_clk              (core_clk),
        .rst_n_i               (rst_n_i),
        .dec_valid_i           (dec_valid),
        .dec_region_i          (dec_region),
        .dec_user_i            (dec_user),
        .dec_write_i           (dec_write),
        .core_rst_b_i          (core_rst_b_o),
        .strap_lsu_user_i      (lsu_user_q),
        .strap_ifu_user_i      (ifu_user_q),
        .strap_dma_user_i      (dma_user_q),
        .strap_sram_cfg_user_i (sram_cfg_user_q),
        .strap_mci_cfg_user_i  (mci_cfg_user_q),
        .exe_valid_o           (exe_valid),
        .exe_grant_o           (exe_grant),
        .exe_err_o             (exe_err),
        .exe_region_o          (exe_region)
    );

    soc_access_result u_result (
        .core_clk      (core_clk),
        .rst_n_i       (rst_n_i),
        .exe_valid_i   (exe_valid),
        .exe_grant_i   (exe_grant),
        .exe_err_i     (exe_err),
        .exe_region_i  (exe_region),
        .resp_valid_o  (resp_valid_o),
        .resp_grant_o  (resp_grant_o),
        .resp_err_o    (resp_err_o),
        .resp_region_o (resp_region_o),
        .deny_count_o  (deny_count_o)
    );

    ////////////////////
    // Reset sequencer
    ////////////////////
    soc_rst_seq #(
        .RST_DELAY_CYCLES(RST_DELAY_CYCLES)
    ) u_rst_seq (
        .core_clk                (core_clk),
        .rst_n_i                 (rst_n_i),
        .hard_rst_assert_req_i   (hard_rst_assert_req_i),
        .hard_rst_release_req_i  (hard_rst_release_req_i),
        .core_rst_assert_req_i   (core_rst_assert_req_i),
        .core_rst_release_req_i  (core_rst_release_req_i),
        .pwrgood_o               (pwrgood_o),
        .core_rst_b_o            (core_rst_b_o),
        .hard_rst_assert_done_o  (hard_rst_assert_done_o),
        .hard_rst_release_done_o (hard_rst_release_done_o),
        .core_rst_assert_done_o  (core_rst_assert_done_o),
        .core_rst_release_done_o (core_rst_release_done_o)
    );

endmodule

// File: verif/soc_access_tb.sv
/*
  Testbench for the SoC access gate.
  Reads operations from verif/access_input.txt, drives requests and reset
  steps into soc_access_top and checks responses, reset levels, done
  pulses and the denial count against the expected columns of the file.
*/
`timescale 1ns/1ns

module soc_access_tb;

    localparam int MAX_OPS = 64;

    logic        core_clk = 1'b0;
    logic        rst_n_i;
    logic        hard_rst_assert_req_i;
    logic        hard_rst_release_req_i;
    logic        core_rst_assert_req_i;
    logic        core_rst_release_req_i;
    logic        req_valid_i;
    logic [31:0] req_addr_i;
    logic [31:0] req_user_i;
    logic        req_write_i;

    logic                     pwrgood_o;
    logic                     core_rst_b_o;
    logic                     hard_rst_assert_done_o;
    logic                     hard_rst_release_done_o;
    logic                     core_rst_assert_done_o;
    logic                     core_rst_release_done_o;
    logic                     resp_valid_o;
    logic                     resp_grant_o;
    soc_map_pkg::access_err_e resp_err_o;
    soc_map_pkg::region_e     resp_region_o;
    logic [15:0]              deny_count_o;

    // Five strap users, then one foreign user
    logic [31:0] users [0:5];
    logic [55:0] ops [0:MAX_OPS-1];

    int n_ops       = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 1000000;
    int errors      = 0;
    int resp_count  = 0;
    int exp_denials = 0;

    // Expected responses in request order
    logic       exp_grant_q [$];
    logic [1:0] exp_err_q [$];
    logic [1:0] exp_region_q [$];
    int         exp_cycle_q [$];

    soc_access_top #(
        .MCU_SRAM_SIZE_KB(512),
        .RST_DELAY_CYCLES(8)
    ) DUT (
        .core_clk                (core_clk),
        .rst_n_i                 (rst_n_i),
        .hard_rst_assert_req_i   (hard_rst_assert_req_i),
        .hard_rst_release_req_i  (hard_rst_release_req_i),
        .core_rst_assert_req_i   (core_rst_assert_req_i),
        .core_rst_release_req_i  (core_rst_release_req_i),
        .strap_lsu_user_i        (users[0]),
        .strap_ifu_user_i        (users[1]),
        .strap_dma_user_i        (users[2]),
        .strap_sram_cfg_user_i   (users[3]),
        .strap_mci_cfg_user_i    (users[4]),
        .req_valid_i             (req_valid_i),
        .req_addr_i              (req_addr_i),
        .req_user_i              (req_user_i),
        .req_write_i             (req_write_i),
        .pwrgood_o               (pwrgood_o),
        .core_rst_b_o            (core_rst_b_o),
        .hard_rst_assert_done_o  (hard_rst_assert_done_o),
        .hard_rst_release_done_o (hard_rst_release_done_o),
        .core_rst_assert_done_o  (core_rst_assert_done_o),
        .core_rst_release_done_o (core_rst_release_done_o),
        .resp_valid_o            (resp_valid_o),
        .resp_grant_o            (resp_grant_o),
        .resp_err_o              (resp_err_o),
        .resp_region_o           (resp_region_o),
        .deny_count_o            (deny_count_o)
    );

    ////////////////////
    // Clock and run limit
    ////////////////////
    always #10 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run stopped at cycle %0d, cycle limit reached", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    // Foreign user must not alias any strap
    function automatic logic users_distinct();
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 6; i++) begin
            for (int j = i + 1; j < 6; j++) begin
                if (users[i] == users[j]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    // Selector 0..4 picks a strap, anything above is foreign
    function automatic logic [31:0] user_for(input logic [3:0] sel);
        if (sel > 4'd5) begin
            return users[5];
        end
        return users[sel[2:0]];
    endfunction

    function automatic logic done_for(input logic [1:0] kind);
        case (kind)
            2'd0:    return hard_rst_assert_done_o;
            2'd1:    return hard_rst_release_done_o;
            2'd2:    return core_rst_assert_done_o;
            default: return core_rst_release_done_o;
        endcase
    endfunction

    // One request per call, so request lines run back to back
    task automatic send_request(input logic [55:0] op);
        @(posedge core_clk);
        #2;
        req_valid_i = 1'b1;
        req_addr_i  = op[51:20];
        req_user_i  = user_for(op[19:16]);
        req_write_i = op[12];
        exp_grant_q.push_back(op[8]);
        exp_err_q.push_back(op[5:4]);
        exp_region_q.push_back(op[1:0]);
        exp_cycle_q.push_back(cycle_cnt);
        if (!op[8]) begin
            exp_denials++;
        end
    endtask

    // Pulse one sequencer request, wait for its done, check both levels
    task automatic reset_step(input logic [55:0] op);
        logic [1:0] kind;
        logic       seen;
        int         waited;
        kind   = op[17:16];
        seen   = 1'b0;
        waited = 0;
        @(posedge core_clk);
        #2;
        req_valid_i            = 1'b0;
        hard_rst_assert_req_i  = (kind == 2'd0);
        hard_rst_release_req_i = (kind == 2'd1);
        core_rst_assert_req_i  = (kind == 2'd2);
        core_rst_release_req_i = (kind == 2'd3);
        @(posedge core_clk);
        #2;
        hard_rst_assert_req_i  = 1'b0;
        hard_rst_release_req_i = 1'b0;
        core_rst_assert_req_i  = 1'b0;
        core_rst_release_req_i = 1'b0;
        while (!seen && waited < 40) begin
            @(negedge core_clk);
            seen = done_for(kind);
            waited++;
        end
        if (!seen) begin
            errors++;
            $display("No done pulse at %0t for reset request kind %0d", $time, kind);
        end else if (waited != 8) begin
            // Pulse driven after edge K, level and done after edge K+8
            errors++;
            $display("Done pulse at %0t came %0d cycles after reset request kind %0d",
                     $time, waited, kind);
        end
        // Levels as they stand in the done cycle
        if (pwrgood_o !== op[8]) begin
            errors++;
            $display("FAIL %0t pwrgood_o: got %b expected %b", $time, pwrgood_o, op[8]);
        end
        if (core_rst_b_o !== op[4]) begin
            errors++;
            $display("FAIL %0t core_rst_b_o: got %b expected %b", $time, core_rst_b_o, op[4]);
        end
    endtask

    ////////////////////
    // Response monitor
    ////////////////////
    always @(negedge core_clk) begin : resp_monitor
        logic       exp_g;
        logic [1:0] exp_e;
        logic [1:0] exp_r;
        int         issued;
        if (resp_valid_o === 1'b1) begin
            if (exp_grant_q.size() == 0) begin
                errors++;
                $display("Response at %0t without an outstanding request", $time);
            end else begin
                exp_g  = exp_grant_q.pop_front();
                exp_e  = exp_err_q.pop_front();
                exp_r  = exp_region_q.pop_front();
                issued = exp_cycle_q.pop_front();
                resp_count++;
                // Driven after edge K, answered after edge K+3
                if (cycle_cnt - issued != 3) begin
                    errors++;
                    $display("Response at %0t came %0d cycles after its request",
                             $time, cycle_cnt - issued);
                end
                if (resp_grant_o !== exp_g) begin
                    errors++;
                    $display("FAIL %0t resp_grant_o: got %0d expected %0d",
                             $time, resp_grant_o, exp_g);
                end
                if (resp_err_o !== exp_e) begin
                    errors++;
                    $display("FAIL %0t resp_err_o: got %0d expected %0d",
                             $time, resp_err_o, exp_e);
                end
                if (resp_region_o !== exp_r) begin
                    errors++;
                    $display("FAIL %0t resp_region_o: got %0d expected %0d",
                             $time, resp_region_o, exp_r);
                end
            end
        end
    end

    ////////////////////
    // Main flow
    ////////////////////
    initial begin : main_flow
        int n;
        rst_n_i                = 1'b0;
        hard_rst_assert_req_i  = 1'b0;
        hard_rst_release_req_i = 1'b0;
        core_rst_assert_req_i  = 1'b0;
        core_rst_release_req_i = 1'b0;
        req_valid_i            = 1'b0;
        req_addr_i             = '0;
        req_user_i             = '0;
        req_write_i            = 1'b0;

        void'($urandom(32'h16f7));
        do begin
            for (int i = 0; i < 6; i++) begin
                users[i] = $urandom();
            end
        end while (!users_distinct());

        for (int i = 0; i < MAX_OPS; i++) begin
            ops[i] = '0;
        end
        $readmemh("verif/access_input.txt", ops);
        // Zero op code marks the end of the list
        while (n_ops < MAX_OPS && ops[n_ops][55:52] != 4'h0) begin
            n_ops++;
        end
        if (n_ops == 0) begin
            errors++;
            $display("Input file holds no operations");
        end
        cycle_limit = 40 * n_ops + 200;

        // Straps follow the pins during these cycles
        repeat (10) @(posedge core_clk);
        #1;
        if ({resp_valid_o, resp_grant_o, pwrgood_o, core_rst_b_o, hard_rst_assert_done_o,
             hard_rst_release_done_o, core_rst_assert_done_o,
             core_rst_release_done_o} !== 8'h00) begin
            errors++;
            $display("FAIL %0t outputs in reset: got %b expected 00000000", $time,
                     {resp_valid_o, resp_grant_o, pwrgood_o, core_rst_b_o,
                      hard_rst_assert_done_o, hard_rst_release_done_o,
                      core_rst_assert_done_o, core_rst_release_done_o});
        end
        if (deny_count_o !== 16'h0) begin
            errors++;
            $display("FAIL %0t deny_count_o: got %0d expected 0", $time, deny_count_o);
        end
        #1;
        rst_n_i = 1'b1;

        // Power-up order, 8 edges each
        n = 0;
        while (pwrgood_o !== 1'b1 && n < 40) begin
            @(posedge core_clk);
            @(negedge core_clk);
            n++;
        end
        if (n != 8) begin
            errors++;
            $display("FAIL %0t pwrgood_o rise delay: got %0d expected 8", $time, n);
        end
        n = 0;
        while (core_rst_b_o !== 1'b1 && n < 40) begin
            @(posedge core_clk);
            @(negedge core_clk);
            n++;
        end
        if (n != 8) begin
            errors++;
            $display("FAIL %0t core_rst_b_o rise delay: got %0d expected 8", $time, n);
        end

        for (int i = 0; i < n_ops; i++) begin
            case (ops[i][55:52])
                4'h1: send_request(ops[i]);
                4'h2: reset_step(ops[i]);
                default: begin
                    errors++;
                    $display("Unknown operation code in input entry %0d", i);
                end
            endcase
        end

        // Drain the pipeline, then a few idle cycles
        @(posedge core_clk);
        #2;
        req_valid_i = 1'b0;
        n = 0;
        while (exp_grant_q.size() != 0 && n < 10) begin
            @(negedge core_clk);
            n++;
        end
        repeat (4) @(negedge core_clk);
        if (exp_grant_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived", exp_grant_q.size());
        end
        if (deny_count_o !== 16'(exp_denials)) begin
            errors++;
            $display("FAIL %0t deny_count_o: got %0d expected %0d",
                     $time, deny_count_o, exp_denials);
        end

        $display("Errors: %0d, responses checked: %0d", errors, resp_count);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verif/access_input.txt
// Columns, hex: op(1) addr(8) sel(1) wr(1) grant(1) err(1) region(1)
// op 1 request, sel 0 lsu 1 ifu 2 dma 3 sram_cfg 4 mci_cfg 5 foreign
// op 2 reset step, sel 0 hard assert 1 hard release 2 core assert 3 core release,
//   grant and err columns then hold expected pwrgood and core_rst_b
1_21000000_0_1_1_0_1 // LSU write to SRAM
1_21000100_2_1_1_0_1 // DMA write to SRAM
1_2107fffc_1_0_1_0_1 // IFU read of the last SRAM word
1_21000200_1_1_0_2_1 // IFU write refused
1_21080000_0_0_0_1_0 // First byte past SRAM
1_21200010_3_1_1_0_2 // SRAM config user on own window
1_21200020_4_0_0_2_2 // MCI user on SRAM config
1_21300ffc_4_1_1_0_3 // MCI config user on own window
1_21300000_0_0_0_2_3 // LSU on MCI config
1_21000040_5_0_0_2_1 // Foreign user on SRAM
1_21201000_3_0_0_1_0 // Past the SRAM config window
2_00000000_2_0_1_0_0 // Core reset assert
1_21000000_0_0_0_3_1
1_21300000_4_1_0_3_3
2_00000000_3_0_1_1_0 // Core reset release
1_21000080_2_0_1_0_1
2_00000000_0_0_0_0_0 // Hard reset assert drops both
2_00000000_3_0_0_0_0 // Core release ignored without power good
1_21000000_0_0_0_3_1
2_00000000_1_0_1_0_0 // Hard reset release
2_00000000_3_0_1_1_0
1_21200000_3_0_1_0_2
1_31000000_5_1_0_1_0 // Unmapped address

// File: sim.f
verilog/soc_map_pkg.sv
verilog/soc_rst_pkg.sv
verilog/soc_addr_decode.sv
verilog/soc_user_check.sv
verilog/soc_access_result.sv
verilog/soc_rst_seq.sv
verilog/soc_access_top.sv
verif/soc_access_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the access gate testbench with Verilator and run it.
# Exits non-zero unless the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f sim.f \
    --top-module soc_access_tb -o soc_access_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/soc_access_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qF 'All tests passed!' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
